// ==== build.f ====
+incdir+include
hdl/noise_pkg.sv
hdl/frame_sequencer.sv
hdl/noise_regs.sv
hdl/period_timer.sv
hdl/noise_generator.sv
hdl/envelope_unit.sv
hdl/length_counter.sv
hdl/noise_channel.sv
verif/noise_checker.sv
verif/noise_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f build.f --top-module noise_tb \
	--Mdir obj_dir -o noise_sim

./obj_dir/noise_sim | tee sim.log

if grep -qx "Verification passed" sim.log; then
	echo "simulation run passed"
	exit 0
fi

echo "simulation run did not pass"
exit 1

// ==== verif/noise_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "noise_settings.svh"

module noise_tb;

	import noise_pkg::*;

	logic aclk;
	logic reset;
	noise_write_t wr;
	logic [`NOISE_VOL_WIDTH-1:0] sample;
	logic length_active;
	logic row_end;
	logic [159:0] row_name;
	logic exp_active;
	int rows_done;
	int rows_failed;
	int cycle_count;
	int cycle_limit;

	// stimulus table, one entry per test
	logic [159:0] tbl_name [$];
	logic [1:0] tbl_addr [$];
	logic [7:0] tbl_data [$];
	int tbl_cycles [$];
	logic tbl_active [$];
	logic tbl_rand_vol [$];

	noise_channel i_noise_channel (
		.aclk(aclk),
		.reset(reset),
		.wr(wr),
		.sample(sample),
		.length_active(length_active)
	);

	noise_checker i_noise_checker (
		.aclk(aclk),
		.reset(reset),
		.wr(wr),
		.sample(sample),
		.length_active(length_active),
		.row_end(row_end),
		.row_name(row_name),
		.exp_active(exp_active),
		.rows_done(rows_done),
		.rows_failed(rows_failed)
	);

	initial begin
		aclk = 1'b0;
		forever #20 aclk = ~aclk;
	end

	always @(posedge aclk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("run timed out after %0d cycles", cycle_count);
			$display("Verification failed");
			$finish;
		end
	end

	task automatic add_row(input logic [159:0] name, input logic [1:0] addr,
		input logic [7:0] data, input int cycles, input logic active, input logic rand_vol);
		tbl_name.push_back(name);
		tbl_addr.push_back(addr);
		tbl_data.push_back(data);
		tbl_cycles.push_back(cycles);
		tbl_active.push_back(active);
		tbl_rand_vol.push_back(rand_vol);
	endtask

	// one write in the first cycle, then idle to the end of the row
	task automatic apply_row(input int idx, input logic [3:0] vol);
		logic [7:0] data;
		data = tbl_data[idx];
		if (tbl_rand_vol[idx])
			data = {data[7:4], vol};
		row_name = tbl_name[idx];
		exp_active = tbl_active[idx];
		wr.en = 1'b1;
		wr.addr = tbl_addr[idx];
		wr.data = data;
		row_end = (tbl_cycles[idx] == 1);
		for (int i = 1; i <= tbl_cycles[idx]; i++) begin
			@(posedge aclk);
			#2;
			wr.en = 1'b0;
			row_end = (i == tbl_cycles[idx] - 1);
		end
	endtask

	initial begin
		int total;
		logic [3:0] vol;
		void'($urandom(32'h5454_e436));
		reset = 1'b1;
		wr = '0;
		row_end = 1'b0;
		row_name = '0;
		exp_active = 1'b0;
		cycle_limit = 0;
		add_row("reset_idle", 2'd1, 8'h00, 14912, 1'b0, 1'b0); // one sequencer cycle
		add_row("len2_high", 2'd3, 8'h18, 8000, 1'b1, 1'b0); // index 3
		add_row("len2_low", 2'd1, 8'h00, 8000, 1'b0, 1'b0);
		add_row("len4_high", 2'd3, 8'h28, 28000, 1'b1, 1'b0); // index 5
		add_row("len4_low", 2'd1, 8'h00, 2000, 1'b0, 1'b0);
		add_row("cv_control", 2'd0, 8'h10, 16, 1'b0, 1'b1);
		add_row("cv_period_long", 2'd2, 8'h00, 16, 1'b0, 1'b0);
		add_row("cv_length", 2'd3, 8'h08, 20000, 1'b1, 1'b0);
		add_row("short_period4", 2'd2, 8'h84, 20000, 1'b1, 1'b0);
		add_row("loop_control", 2'd0, 8'h20, 16, 1'b1, 1'b0); // halt and loop set
		add_row("halt_len2_loop", 2'd3, 8'h18, 74560, 1'b1, 1'b0);
		add_row("once_control", 2'd0, 8'h00, 16, 1'b1, 1'b0);
		add_row("once_len254", 2'd3, 8'h08, 74560, 1'b1, 1'b0);
		total = 4;
		foreach (tbl_cycles[i])
			total += tbl_cycles[i];
		cycle_limit = total + total / 5;
		vol = 4'($urandom_range(15, 1)); // non-zero so the level is audible
		repeat (4) @(posedge aclk);
		#2;
		reset = 1'b0;
		for (int i = 0; i < tbl_name.size(); i++)
			apply_row(i, vol);
		row_end = 1'b0;
		$display("tests run %0d, tests failed %0d", rows_done, rows_failed);
		if (rows_failed == 0 && rows_done == tbl_name.size())
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/noise_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "noise_settings.svh"

module noise_checker (
	input wire aclk,
	input wire reset,
	input noise_pkg::noise_write_t wr,
	input wire [`NOISE_VOL_WIDTH-1:0] sample,
	input wire length_active,
	input wire row_end,
	input wire [159:0] row_name,
	input wire exp_active,
	output int rows_done,
	output int rows_failed
);

	import noise_pkg::*;

	int seq_cnt;
	int seq_step;
	int timer_left; // cycles until the next shift
	int row_errors;
	logic [`NOISE_LFSR_WIDTH-1:0] lfsr;
	logic [7:0] count;
	logic [`NOISE_VOL_WIDTH-1:0] divider;
	logic [`NOISE_VOL_WIDTH-1:0] decay;
	logic start;
	noise_reg_word_u ctrl; // last control write
	noise_reg_word_u period; // last period write

	// reference model, advanced once per audio cycle
	always @(posedge aclk) begin
		noise_reg_word_u word;
		logic quarter;
		logic half;
		logic load;
		word = wr.data;
		quarter = (seq_cnt == `NOISE_QUARTER_CYCLES - 1);
		half = quarter && (seq_step % 2 == 1); // end of steps 2 and 4
		load = wr.en && (wr.addr == 2'd3);
		if (reset) begin
			seq_cnt = 0;
			seq_step = 0;
			timer_left = noise_period_table[0];
			lfsr = `NOISE_LFSR_SEED;
			count = '0;
			divider = '0;
			decay = '0;
			start = 1'b0;
			ctrl = '0;
			period = '0;
		end else begin
			seq_cnt = quarter ? 0 : seq_cnt + 1;
			if (quarter)
				seq_step = (seq_step + 1) % 4;
			timer_left = timer_left - 1;
			if (timer_left == 0) begin
				lfsr = {lfsr[0] ^ (period.period.mode ? lfsr[6] : lfsr[1]),
					lfsr[`NOISE_LFSR_WIDTH-1:1]};
				timer_left = noise_period_table[period.period.index];
			end
			if (quarter && start) begin
				decay = 4'd15;
				divider = ctrl.ctrl.volume;
			end else if (quarter && divider == 0) begin
				divider = ctrl.ctrl.volume;
				if (decay != 0)
					decay = decay - 4'd1;
				else if (ctrl.ctrl.halt_loop)
					decay = 4'd15; // wrap in loop mode
			end else if (quarter) begin
				divider = divider - 4'd1;
			end
			start = load || (start && !quarter);
			if (load)
				count = noise_length_table[word.length.index];
			else if (half && !ctrl.ctrl.halt_loop && count != 0)
				count = count - 8'd1;
			if (wr.en && wr.addr == 2'd0)
				ctrl = word;
			if (wr.en && wr.addr == 2'd2)
				period = word;
		end
	end

	// outputs are settled by the falling edge
	always @(negedge aclk) begin
		logic [`NOISE_VOL_WIDTH-1:0] exp_sample;
		exp_sample = ctrl.ctrl.const_vol ? ctrl.ctrl.volume : decay;
		if (lfsr[0] || count == 0)
			exp_sample = '0;
		if (reset) begin
			rows_done = 0;
			rows_failed = 0;
			row_errors = 0;
		end else begin
			if (sample !== exp_sample) begin
				if (row_errors == 0)
					$display("[FAIL] %0s: sample expected %0d actual %0d",
						row_name, exp_sample, sample);
				row_errors++;
			end
			if (length_active !== (count != 0)) begin
				if (row_errors == 0)
					$display("[FAIL] %0s: length_active expected %0b actual %0b",
						row_name, count != 0, length_active);
				row_errors++;
			end
			if (row_end) begin
				if (length_active !== exp_active) begin
					$display("[FAIL] %0s: final length_active expected %0b actual %0b",
						row_name, exp_active, length_active);
					row_errors++;
				end
				if (row_errors == 0) begin
					$display("[PASS] %0s", row_name);
				end else begin
					$display("[FAIL] %0s: %0d mismatching checks", row_name, row_errors);
					rows_failed++;
				end
				rows_done++;
				row_errors = 0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/noise_channel.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "noise_settings.svh"

module noise_channel (
	input wire aclk,
	input wire reset,
	input noise_pkg::noise_write_t wr,
	output logic [`NOISE_VOL_WIDTH-1:0] sample,
	output logic length_active
);

	import noise_pkg::*;

	frame_tick_t tick;
	logic halt_loop;
	logic const_vol;
	logic [`NOISE_VOL_WIDTH-1:0] volume;
	logic mode;
	logic [3:0] period_index;
	logic length_load;
	logic [4:0] length_index;
	logic env_restart;
	logic step;
	logic [`NOISE_VOL_WIDTH-1:0] env_volume;
	logic active;

	noise_regs i_noise_regs (
		.aclk(aclk),
		.reset(reset),
		.wr(wr),
		.halt_loop(halt_loop),
		.const_vol(const_vol),
		.volume(volume),
		.mode(mode),
		.period_index(period_index),
		.length_load(length_load),
		.length_index(length_index),
		.env_restart(env_restart)
	);

	frame_sequencer i_frame_sequencer (
		.aclk(aclk),
		.reset(reset),
		.tick(tick)
	);

	period_timer i_period_timer (
		.aclk(aclk),
		.reset(reset),
		.period_index(period_index),
		.step(step)
	);

	envelope_unit i_envelope_unit (
		.aclk(aclk),
		.reset(reset),
		.tick(tick),
		.env_restart(env_restart),
		.halt_loop(halt_loop),
		.const_vol(const_vol),
		.volume(volume),
		.volume_out(env_volume)
	);

	length_counter i_length_counter (
		.aclk(aclk),
		.reset(reset),
		.tick(tick),
		.halt_loop(halt_loop),
		.length_load(length_load),
		.length_index(length_index),
		.active(active)
	);

	noise_generator i_noise_generator (
		.aclk(aclk),
		.reset(reset),
		.step(step),
		.mode(mode),
		.volume(env_volume),
		.active(active),
		.sample(sample)
	);

	assign length_active = active;

endmodule

`default_nettype wire

// ==== hdl/length_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "noise_settings.svh"

module length_counter (
	input wire aclk,
	input wire reset,
	input noise_pkg::frame_tick_t tick,
	input wire halt_loop,
	input wire length_load,
	input wire [4:0] length_index,
	output logic active
);

	import noise_pkg::*;

	logic [7:0] count;
	logic dec_en;

	// halt shares its bit with the envelope loop flag
	assign dec_en = tick.half && !halt_loop && (count != '0);

	always_ff @(posedge aclk) begin
		if (reset) begin
			count <= '0;
		end else if (length_load) begin
			count <= noise_length_table[length_index]; // load wins over a half tick
		end else if (dec_en) begin
			count <= count - 1'b1;
		end
	end

	assign active = (count != '0);

	// an empty counter stays empty until the next load
	assert property (@(posedge aclk) disable iff (reset)
		(count == '0) && !length_load |=> (count == '0));

endmodule

`default_nettype wire

// ==== hdl/envelope_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "noise_settings.svh"

module envelope_unit (
	input wire aclk,
	input wire reset,
	input noise_pkg::frame_tick_t tick,
	input wire env_restart,
	input wire halt_loop,
	input wire const_vol,
	input wire [`NOISE_VOL_WIDTH-1:0] volume,
	output logic [`NOISE_VOL_WIDTH-1:0] volume_out
);

	logic start;
	logic [`NOISE_VOL_WIDTH-1:0] divider;
	logic [`NOISE_VOL_WIDTH-1:0] decay;

	always_ff @(posedge aclk) begin
		if (reset) begin
			start <= 1'b0;
		end else if (env_restart) begin
			start <= 1'b1;
		end else if (tick.quarter) begin
			start <= 1'b0;
		end
	end

	always_ff @(posedge aclk) begin
		if (reset) begin
			divider <= '0;
			decay <= '0;
		end else if (tick.quarter) begin
			if (start) begin
				divider <= volume;
				decay <= '1; // restart at full level
			end else if (divider == '0) begin
				divider <= volume;
				if (decay != '0)
					decay <= decay - 1'b1;
				else if (halt_loop)
					decay <= '1; // loop back to 15
			end else begin
				divider <= divider - 1'b1;
			end
		end
	end

	assign volume_out = const_vol ? volume : decay;

endmodule

`default_nettype wire

// ==== hdl/noise_generator.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "noise_settings.svh"

module noise_generator (
	input wire aclk,
	input wire reset,
	input wire step,
	input wire mode,
	input wire [`NOISE_VOL_WIDTH-1:0] volume,
	input wire active,
	output logic [`NOISE_VOL_WIDTH-1:0] sample
);

	logic [`NOISE_LFSR_WIDTH-1:0] lfsr;
	logic tap;
	logic feedback;

	assign tap = mode ? lfsr[6] : lfsr[1]; // short mode uses bit 6
	assign feedback = lfsr[0] ^ tap;

	always_ff @(posedge aclk) begin
		if (reset) begin
			lfsr <= `NOISE_LFSR_SEED;
		end else if (step) begin
			lfsr <= {feedback, lfsr[`NOISE_LFSR_WIDTH-1:1]};
		end
	end

	// silent when bit 0 is set or the length has run out
	assign sample = (!lfsr[0] && active) ? volume : '0;

	// an all-zero register would lock up for good
	assert property (@(posedge aclk) disable iff (reset)
		lfsr != '0);

endmodule

`default_nettype wire

// ==== hdl/period_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "noise_settings.svh"

module period_timer (
	input wire aclk,
	input wire reset,
	input wire [3:0] period_index,
	output logic step
);

	import noise_pkg::*;

	logic [`NOISE_TIMER_WIDTH-1:0] count;

	assign step = (count == '0);

	always_ff @(posedge aclk) begin
		if (reset) begin
			count <= noise_period_table[0] - 1'b1; // index is 0 out of reset
		end else if (step) begin
			count <= noise_period_table[period_index] - 1'b1; // index sampled here only
		end else begin
			count <= count - 1'b1;
		end
	end

	// reload value bounds the count
	assert property (@(posedge aclk) disable iff (reset)
		count < noise_period_table[15]);

endmodule

`default_nettype wire

// ==== hdl/noise_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "noise_settings.svh"

module noise_regs (
	input wire aclk,
	input wire reset,
	input noise_pkg::noise_write_t wr,
	output logic halt_loop,
	output logic const_vol,
	output logic [`NOISE_VOL_WIDTH-1:0] volume,
	output logic mode,
	output logic [3:0] period_index,
	output logic length_load,
	output logic [4:0] length_index,
	output logic env_restart
);

	import noise_pkg::*;

	noise_reg_word_u word;

	assign word = wr.data;

	always_ff @(posedge aclk) begin
		if (reset) begin
			halt_loop <= 1'b0;
			const_vol <= 1'b0;
			volume <= '0;
			mode <= 1'b0;
			period_index <= '0;
		end else if (wr.en) begin
			if (wr.addr == addr_control) begin
				halt_loop <= word.ctrl.halt_loop;
				const_vol <= word.ctrl.const_vol;
				volume <= word.ctrl.volume;
			end else if (wr.addr == addr_period) begin
				mode <= word.period.mode;
				period_index <= word.period.index;
			end // address 1 has no register
		end
	end

	// length write loads the counter at this edge
	assign length_load = wr.en && (wr.addr == addr_length);
	assign length_index = word.length.index;
	assign env_restart = length_load; // same write restarts the envelope

endmodule

`default_nettype wire

// ==== hdl/frame_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "noise_settings.svh"

module frame_sequencer (
	input wire aclk,
	input wire reset,
	output noise_pkg::frame_tick_t tick
);

	localparam int cnt_width = $clog2(`NOISE_QUARTER_CYCLES);
	localparam logic [cnt_width-1:0] cnt_last = cnt_width'(`NOISE_QUARTER_CYCLES - 1);

	typedef enum logic [1:0] {
		step1,
		step2,
		step3,
		step4
	} seq_state_t;

	seq_state_t state;
	seq_state_t state_next;
	logic [cnt_width-1:0] cnt;
	logic step_end;

	assign step_end = (cnt == cnt_last); // last cycle of the step

	always_comb begin
		case (state)
			step1: state_next = step2;
			step2: state_next = step3;
			step3: state_next = step4;
			default: state_next = step1;
		endcase
	end

	always_ff @(posedge aclk) begin
		if (reset) begin
			cnt <= '0;
			state <= step1;
		end else if (step_end) begin
			cnt <= '0;
			state <= state_next;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	always_comb begin
		tick.quarter = step_end;
		tick.half = 1'b0;
		if (state == step2 || state == step4)
			tick.half = step_end; // half frame after steps 2 and 4
	end

	// a half tick comes with a quarter tick and is followed by an odd step
	assert property (@(posedge aclk) disable iff (reset)
		tick.half |=> $past(tick.quarter) && (state == step1 || state == step3));

endmodule

`default_nettype wire

// ==== hdl/noise_pkg.sv ====
`default_nettype none

`include "noise_settings.svh"

package noise_pkg;

	localparam logic [1:0] addr_control = 2'd0;
	localparam logic [1:0] addr_period = 2'd2;
	localparam logic [1:0] addr_length = 2'd3;

	typedef struct packed {
		logic en;
		logic [1:0] addr;
		logic [7:0] data;
	} noise_write_t;

	typedef struct packed {
		logic [1:0] rsvd;
		logic halt_loop;
		logic const_vol;
		logic [`NOISE_VOL_WIDTH-1:0] volume;
	} noise_ctrl_view_t;

	typedef struct packed {
		logic mode; // 1 selects the short sequence
		logic [2:0] rsvd;
		logic [3:0] index;
	} noise_period_view_t;

	typedef struct packed {
		logic [4:0] index;
		logic [2:0] rsvd;
	} noise_length_view_t;

	// one data byte, meaning depends on the address
	typedef union packed {
		noise_ctrl_view_t ctrl;
		noise_period_view_t period;
		noise_length_view_t length;
	} noise_reg_word_u;

	typedef struct packed {
		logic quarter;
		logic half;
	} frame_tick_t;

	localparam logic [`NOISE_TIMER_WIDTH-1:0] noise_period_table [16] = '{
		12'd2, 12'd4, 12'd8, 12'd16, 12'd32, 12'd48, 12'd64, 12'd80,
		12'd101, 12'd127, 12'd190, 12'd254, 12'd381, 12'd508, 12'd1017, 12'd2034
	};

	localparam logic [7:0] noise_length_table [32] = '{
		8'd10, 8'd254, 8'd20, 8'd2, 8'd40, 8'd4, 8'd80, 8'd6,
		8'd160, 8'd8, 8'd60, 8'd10, 8'd14, 8'd12, 8'd26, 8'd14,
		8'd12, 8'd16, 8'd24, 8'd18, 8'd48, 8'd20, 8'd96, 8'd22,
		8'd192, 8'd24, 8'd72, 8'd26, 8'd16, 8'd28, 8'd32, 8'd30
	};

endpackage

`default_nettype wire

// ==== include/noise_settings.svh ====
`ifndef NOISE_SETTINGS_SVH
`define NOISE_SETTINGS_SVH

// random shift register
`define NOISE_LFSR_WIDTH 15
`define NOISE_LFSR_SEED 15'd1

// period timer
`define NOISE_TIMER_WIDTH 12

// audio cycles in one sequencer step
`define NOISE_QUARTER_CYCLES 3728

// sample and envelope level width
`define NOISE_VOL_WIDTH 4

`endif
